/* dram_app_pkg.sv */
// shared widths, enums and structs for the dram application bridge, imported by every module
package dram_app_pkg;

    localparam int USER_ADDR_W = 32;
    localparam int USER_DATA_W = 32;
    localparam int USER_MASK_W = 4;
    localparam int APP_ADDR_W  = 28;
    localparam int APP_DATA_W  = 128;
    localparam int APP_MASK_W  = 16;
    localparam int LANES       = APP_DATA_W / USER_DATA_W;

    // encodings follow the controller app_cmd field
    typedef enum logic [2:0] {
        CMD_WRITE = 3'b000,
        CMD_READ  = 3'b001
    } app_cmd_e;

    typedef enum logic {
        OP_READ  = 1'b0,
        OP_WRITE = 1'b1
    } req_op_e;

    typedef enum logic {
        ST_CALIB = 1'b0,
        ST_RUN   = 1'b1
    } dispatch_state_e;

    typedef struct packed {
        req_op_e                  op;
        logic [USER_ADDR_W-1:0]   addr;
        logic [USER_DATA_W-1:0]   data;
        logic [USER_MASK_W-1:0]   be;
    } user_req_t;

    typedef struct packed {
        logic                     en;
        app_cmd_e                 cmd;
        logic [APP_ADDR_W-1:0]    addr;
    } app_cmd_t;

    // mask bit set means byte is left untouched
    typedef struct packed {
        logic                     wren;
        logic [APP_DATA_W-1:0]    data;
        logic [APP_MASK_W-1:0]    mask;
    } app_wdf_t;

endpackage

/* app_cmd_port.sv */
// application command register, holds one command on app_en until the controller takes it
`timescale 1ns/10ps

module app_cmd_port import dram_app_pkg::*; (
    input  logic     clk,
    input  logic     rst_x_async,
    input  logic     i_load,
    input  app_cmd_t i_cmd,
    input  logic     i_app_rdy,
    output logic     o_can_load,
    output app_cmd_t o_app_cmd
);

    logic                  en_q;
    app_cmd_e              cmd_q;
    logic [APP_ADDR_W-1:0] addr_q;

    // free when empty or when the held command goes this cycle
    assign o_can_load = !en_q || i_app_rdy;

    always_ff @(posedge clk or negedge rst_x_async) begin
        if (!rst_x_async) begin
            en_q <= 1'b0;
        end else if (i_load) begin
            en_q <= i_cmd.en;
        end else if (i_app_rdy) begin
            en_q <= 1'b0;
        end
    end

    // payload only
    always_ff @(posedge clk) begin
        if (i_load) begin
            cmd_q  <= i_cmd.cmd;
            addr_q <= i_cmd.addr;
        end
    end

    assign o_app_cmd = '{en: en_q, cmd: cmd_q, addr: addr_q};

    a_cmd_hold: assert property (@(posedge clk) disable iff (!rst_x_async)
        (o_app_cmd.en && !i_app_rdy) |=> $stable(o_app_cmd));

endmodule

/* app_wdf_port.sv */
// write-data register, holds one masked beat on app_wdf_wren until the controller takes it
`timescale 1ns/10ps

module app_wdf_port import dram_app_pkg::*; (
    input  logic     clk,
    input  logic     rst_x_async,
    input  logic     i_load,
    input  app_wdf_t i_wdf,
    input  logic     i_app_wdf_rdy,
    output logic     o_can_load,
    output app_wdf_t o_app_wdf
);

    logic                  wren_q;
    logic [APP_DATA_W-1:0] data_q;
    logic [APP_MASK_W-1:0] mask_q;

    // independent of the command register, either side may go first
    assign o_can_load = !wren_q || i_app_wdf_rdy;

    always_ff @(posedge clk or negedge rst_x_async) begin
        if (!rst_x_async) begin
            wren_q <= 1'b0;
        end else if (i_load) begin
            wren_q <= i_wdf.wren;
        end else if (i_app_wdf_rdy) begin
            wren_q <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (i_load) begin
            data_q <= i_wdf.data;
            mask_q <= i_wdf.mask;
        end
    end

    assign o_app_wdf = '{wren: wren_q, data: data_q, mask: mask_q};

    a_no_overrun: assert property (@(posedge clk) disable iff (!rst_x_async)
        i_load |-> o_can_load);

endmodule

/* req_dispatch.sv */
// request acceptance after calibration, builds command and write beat and tracks read credit
`timescale 1ns/10ps

module req_dispatch import dram_app_pkg::*; #(
    parameter int RD_DEPTH = 4
) (
    input  logic      clk,
    input  logic      rst_x_async,
    input  logic      i_init_calib_complete,
    input  logic      i_req_valid,
    input  user_req_t i_req,
    output logic      o_req_ready,
    input  logic      i_cmd_can_load,
    input  logic      i_wdf_can_load,
    output logic      o_cmd_load,
    output app_cmd_t  o_cmd,
    output logic      o_wdf_load,
    output app_wdf_t  o_wdf,
    input  logic      i_rd_line_valid,
    input  logic      i_rsp_pop
);

    localparam int CNT_W = $clog2(RD_DEPTH + 1);

    dispatch_state_e   state;
    logic [CNT_W-1:0]  rd_outstanding;
    logic [CNT_W-1:0]  rd_buffered;
    logic [CNT_W:0]    credit;
    logic              is_write;
    logic              accept;
    logic              rd_accept;
    logic [1:0]        lane;

    always_ff @(posedge clk or negedge rst_x_async) begin
        if (!rst_x_async) begin
            state <= ST_CALIB;
        end else if (state == ST_CALIB && i_init_calib_complete) begin
            state <= ST_RUN;
        end
    end

    // reads in flight plus lines waiting for the user
    assign credit   = rd_outstanding + rd_buffered;
    assign is_write = (i_req.op == OP_WRITE);

    assign o_req_ready = (state == ST_RUN) && i_cmd_can_load &&
                         (is_write ? i_wdf_can_load : (credit < RD_DEPTH));
    assign accept      = i_req_valid && o_req_ready;
    assign rd_accept   = accept && !is_write;

    always_ff @(posedge clk or negedge rst_x_async) begin
        if (!rst_x_async) begin
            rd_outstanding <= '0;
            rd_buffered    <= '0;
        end else begin
            if (rd_accept && !i_rd_line_valid) begin
                rd_outstanding <= rd_outstanding + 1'b1;
            end else if (!rd_accept && i_rd_line_valid) begin
                rd_outstanding <= rd_outstanding - 1'b1;
            end
            if (i_rd_line_valid && !i_rsp_pop) begin
                rd_buffered <= rd_buffered + 1'b1;
            end else if (!i_rd_line_valid && i_rsp_pop) begin
                rd_buffered <= rd_buffered - 1'b1;
            end
        end
    end

    // line index, low three bits zero for a full burst
    assign lane       = i_req.addr[3:2];
    assign o_cmd_load = accept;
    assign o_cmd.en   = 1'b1;
    assign o_cmd.cmd  = is_write ? CMD_WRITE : CMD_READ;
    assign o_cmd.addr = APP_ADDR_W'({i_req.addr[26:4], 3'b000});

    // word in every lane, mask opens only the enabled bytes of one lane
    assign o_wdf_load = accept && is_write;
    assign o_wdf.wren = 1'b1;
    assign o_wdf.data = {LANES{i_req.data}};
    assign o_wdf.mask = ~(APP_MASK_W'(i_req.be) << {lane, 2'b00});

    a_credit_max: assert property (@(posedge clk) disable iff (!rst_x_async)
        credit <= RD_DEPTH);

endmodule

/* rd_return_fifo.sv */
// buffer for lines returned by the controller, drains to the user through valid/ready
`timescale 1ns/10ps

module rd_return_fifo import dram_app_pkg::*; #(
    parameter int RD_DEPTH = 4
) (
    input  logic                  clk,
    input  logic                  rst_x_async,
    input  logic                  i_push,
    input  logic [APP_DATA_W-1:0] i_line,
    input  logic                  i_rsp_ready,
    output logic                  o_rsp_valid,
    output logic [APP_DATA_W-1:0] o_rsp_data,
    output logic                  o_pop
);

    localparam int PTR_W = (RD_DEPTH > 1) ? $clog2(RD_DEPTH) : 1;
    localparam int CNT_W = $clog2(RD_DEPTH + 1);

    logic [APP_DATA_W-1:0] mem [RD_DEPTH];
    logic [PTR_W-1:0]      wr_ptr;
    logic [PTR_W-1:0]      rd_ptr;
    logic [CNT_W-1:0]      count;

    assign o_rsp_valid = (count != '0);
    assign o_rsp_data  = mem[rd_ptr];
    assign o_pop       = o_rsp_valid && i_rsp_ready;

    always_ff @(posedge clk) begin
        if (i_push) begin
            mem[wr_ptr] <= i_line;
        end
    end

    always_ff @(posedge clk or negedge rst_x_async) begin
        if (!rst_x_async) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (i_push) begin
                wr_ptr <= (wr_ptr == PTR_W'(RD_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (o_pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(RD_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            if (i_push && !o_pop) begin
                count <= count + 1'b1;
            end else if (!i_push && o_pop) begin
                count <= count - 1'b1;
            end
        end
    end

    // read credit upstream should make this impossible
    a_no_overflow: assert property (@(posedge clk) disable iff (!rst_x_async)
        i_push |-> (count < RD_DEPTH));

endmodule

/* dram_app_bridge.sv */
// top of the user-side front end, connects the user request/response channels to the app port
`timescale 1ns/10ps

module dram_app_bridge import dram_app_pkg::*; #(
    parameter int RD_DEPTH = 4
) (
    input  logic                  clk,
    input  logic                  rst_x_async,
    input  logic                  i_init_calib_complete,
    // user request
    input  logic                  i_req_valid,
    input  user_req_t             i_req,
    output logic                  o_req_ready,
    // user response
    output logic                  o_rsp_valid,
    output logic [APP_DATA_W-1:0] o_rsp_data,
    input  logic                  i_rsp_ready,
    // application port
    output app_cmd_t              o_app_cmd,
    input  logic                  i_app_rdy,
    output app_wdf_t              o_app_wdf,
    input  logic                  i_app_wdf_rdy,
    input  logic                  i_app_rd_data_valid,
    input  logic [APP_DATA_W-1:0] i_app_rd_data
);

    logic     cmd_can_load;
    logic     wdf_can_load;
    logic     cmd_load;
    logic     wdf_load;
    logic     rsp_pop;
    app_cmd_t cmd;
    app_wdf_t wdf;

    req_dispatch #(
        .RD_DEPTH(RD_DEPTH)
    ) u_dispatch (
        .clk                   (clk),
        .rst_x_async           (rst_x_async),
        .i_init_calib_complete (i_init_calib_complete),
        .i_req_valid           (i_req_valid),
        .i_req                 (i_req),
        .o_req_ready           (o_req_ready),
        .i_cmd_can_load        (cmd_can_load),
        .i_wdf_can_load        (wdf_can_load),
        .o_cmd_load            (cmd_load),
        .o_cmd                 (cmd),
        .o_wdf_load            (wdf_load),
        .o_wdf                 (wdf),
        .i_rd_line_valid       (i_app_rd_data_valid),
        .i_rsp_pop             (rsp_pop)
    );

    app_cmd_port u_cmd_port (
        .clk         (clk),
        .rst_x_async (rst_x_async),
        .i_load      (cmd_load),
        .i_cmd       (cmd),
        .i_app_rdy   (i_app_rdy),
        .o_can_load  (cmd_can_load),
        .o_app_cmd   (o_app_cmd)
    );

    app_wdf_port u_wdf_port (
        .clk           (clk),
        .rst_x_async   (rst_x_async),
        .i_load        (wdf_load),
        .i_wdf         (wdf),
        .i_app_wdf_rdy (i_app_wdf_rdy),
        .o_can_load    (wdf_can_load),
        .o_app_wdf     (o_app_wdf)
    );

    rd_return_fifo #(
        .RD_DEPTH(RD_DEPTH)
    ) u_rd_fifo (
        .clk         (clk),
        .rst_x_async (rst_x_async),
        .i_push      (i_app_rd_data_valid),
        .i_line      (i_app_rd_data),
        .i_rsp_ready (i_rsp_ready),
        .o_rsp_valid (o_rsp_valid),
        .o_rsp_data  (o_rsp_data),
        .o_pop       (rsp_pop)
    );

endmodule

/* tb_app_mem_model.sv */
// behavioral application-port memory for the testbench, random ready stalls and in-order reads
`timescale 1ns/10ps

module tb_app_mem_model import dram_app_pkg::*; (
    input  logic                  clk,
    input  logic                  rst_x_async,
    input  app_cmd_t              i_app_cmd,
    output logic                  o_app_rdy,
    input  app_wdf_t              i_app_wdf,
    output logic                  o_app_wdf_rdy,
    output logic                  o_rd_valid,
    output logic [APP_DATA_W-1:0] o_rd_data
);

    logic [APP_DATA_W-1:0] lines [64];
    app_cmd_t              cmd_q [$];
    app_wdf_t              wdf_q [$];
    logic [APP_DATA_W-1:0] rd_q [$];
    int                    rd_due [$];
    app_cmd_t              head;
    app_wdf_t              beat;
    int                    cyc;
    int                    due;
    int                    last_due;
    int                    idx;
    int                    b;
    int                    j;

    initial begin
        o_app_rdy     = 1'b0;
        o_app_wdf_rdy = 1'b0;
        o_rd_valid    = 1'b0;
        o_rd_data     = '0;
        cyc           = 0;
        last_due      = 0;
        // same fill as the reference memory in the testbench top
        for (b = 0; b < 64 * 16; b++) begin
            lines[b / 16][8 * (b % 16) +: 8] = 8'((b * 37) ^ (b >> 8));
        end
    end

    always @(posedge clk) begin
        if (rst_x_async) begin
            cyc = cyc + 1;
            if (i_app_cmd.en && o_app_rdy) begin
                cmd_q.push_back(i_app_cmd);
            end
            if (i_app_wdf.wren && o_app_wdf_rdy) begin
                wdf_q.push_back(i_app_wdf);
            end
            // in order, a write waits for its beat
            while (cmd_q.size() > 0 && (cmd_q[0].cmd == CMD_READ || wdf_q.size() > 0)) begin
                head = cmd_q.pop_front();
                idx  = int'(head.addr[8:3]);
                if (head.cmd == CMD_READ) begin
                    due = cyc + 1 + int'($urandom % 8);
                    if (due <= last_due) begin
                        due = last_due + 1;
                    end
                    last_due = due;
                    rd_q.push_back(lines[idx]);
                    rd_due.push_back(due);
                end else begin
                    beat = wdf_q.pop_front();
                    for (j = 0; j < APP_MASK_W; j++) begin
                        if (!beat.mask[j]) begin
                            lines[idx][8 * j +: 8] = beat.data[8 * j +: 8];
                        end
                    end
                end
            end
        end
    end

    always @(negedge clk) begin
        o_app_rdy     = ($urandom % 4) != 0;
        o_app_wdf_rdy = ($urandom % 4) != 0;
        if (rd_due.size() > 0 && rd_due[0] <= cyc) begin
            o_rd_valid = 1'b1;
            o_rd_data  = rd_q.pop_front();
            void'(rd_due.pop_front());
        end else begin
            o_rd_valid = 1'b0;
        end
    end

endmodule

/* tb_dram_app_bridge.sv */
// testbench top for the dram application bridge, random requests checked against a byte memory
`timescale 1ns/10ps

module tb_dram_app_bridge import dram_app_pkg::*; ();

    localparam int RD_DEPTH      = 4;
    localparam int N_REQ         = 400;
    localparam int REQ_TIMEOUT   = 200;
    localparam int DRAIN_TIMEOUT = 2000;

    logic                  clk;
    logic                  rst_x_async;
    logic                  i_init_calib_complete;
    logic                  i_req_valid;
    user_req_t             i_req;
    logic                  o_req_ready;
    logic                  o_rsp_valid;
    logic [APP_DATA_W-1:0] o_rsp_data;
    logic                  i_rsp_ready;
    app_cmd_t              app_cmd;
    app_wdf_t              app_wdf;
    logic                  app_rdy;
    logic                  app_wdf_rdy;
    logic                  rd_valid;
    logic [APP_DATA_W-1:0] rd_data;

    logic [7:0]            ref_mem [64 * 16];
    app_cmd_t              exp_cmd [$];
    app_wdf_t              exp_wdf [$];
    logic [APP_DATA_W-1:0] exp_rsp [$];
    int                    n_checks;
    int                    n_err;
    int                    n_acc;
    int                    n_wr;
    int                    n_rd;
    int                    n_cmd;
    int                    n_rd_cmd;
    int                    n_wdf;
    int                    n_rsp;
    bit                    timed_out;
    logic                  acc_d;
    logic                  last_wr;
    logic                  cmd_held;
    logic                  wdf_held;
    logic                  rsp_due;
    app_cmd_t              last_cmd;
    app_cmd_t              held_cmd;
    app_wdf_t              held_wdf;

    dram_app_bridge #(
        .RD_DEPTH(RD_DEPTH)
    ) u_dut (
        .clk                   (clk),
        .rst_x_async           (rst_x_async),
        .i_init_calib_complete (i_init_calib_complete),
        .i_req_valid           (i_req_valid),
        .i_req                 (i_req),
        .o_req_ready           (o_req_ready),
        .o_rsp_valid           (o_rsp_valid),
        .o_rsp_data            (o_rsp_data),
        .i_rsp_ready           (i_rsp_ready),
        .o_app_cmd             (app_cmd),
        .i_app_rdy             (app_rdy),
        .o_app_wdf             (app_wdf),
        .i_app_wdf_rdy         (app_wdf_rdy),
        .i_app_rd_data_valid   (rd_valid),
        .i_app_rd_data         (rd_data)
    );

    tb_app_mem_model u_mem (
        .clk           (clk),
        .rst_x_async   (rst_x_async),
        .i_app_cmd     (app_cmd),
        .o_app_rdy     (app_rdy),
        .i_app_wdf     (app_wdf),
        .o_app_wdf_rdy (app_wdf_rdy),
        .o_rd_valid    (rd_valid),
        .o_rd_data     (rd_data)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic check(input string name, input logic [159:0] got, input logic [159:0] exp);
        n_checks++;
        if (got !== exp) begin
            n_err++;
            $display("error: %s got 0x%0h expected 0x%0h", name, got, exp);
        end
    endtask

    task automatic report_failure(input string what);
        n_err++;
        $display("%s", what);
    endtask

    function automatic user_req_t random_request();
        user_req_t r;
        r.op        = ($urandom % 2) ? OP_WRITE : OP_READ;
        r.addr      = '0;
        r.addr[9:2] = 8'($urandom);
        r.data      = $urandom;
        r.be        = 4'($urandom);
        return r;
    endfunction

    function automatic app_cmd_t expected_cmd(input user_req_t r);
        app_cmd_t c;
        c.en   = 1'b1;
        c.cmd  = (r.op == OP_WRITE) ? CMD_WRITE : CMD_READ;
        c.addr = {2'd0, r.addr[26:4], 3'd0};
        return c;
    endfunction

    function automatic app_wdf_t expected_beat(input user_req_t r);
        app_wdf_t w;
        int       j;
        w.wren = 1'b1;
        for (j = 0; j < LANES; j++) begin
            w.data[USER_DATA_W * j +: USER_DATA_W] = r.data;
        end
        for (j = 0; j < APP_MASK_W; j++) begin
            w.mask[j] = !((j / 4 == int'(r.addr[3:2])) && r.be[j % 4]);
        end
        return w;
    endfunction

    // reference update happens in acceptance order, which is command order
    task automatic record_accept(input user_req_t r);
        int                    base;
        int                    k;
        logic [APP_DATA_W-1:0] line;
        base = int'(r.addr[9:4]) * 16;
        exp_cmd.push_back(expected_cmd(r));
        if (r.op == OP_WRITE) begin
            exp_wdf.push_back(expected_beat(r));
            for (k = 0; k < USER_MASK_W; k++) begin
                if (r.be[k]) begin
                    ref_mem[base + int'(r.addr[3:2]) * 4 + k] = r.data[8 * k +: 8];
                end
            end
            n_wr++;
        end else begin
            for (k = 0; k < 16; k++) begin
                line[8 * k +: 8] = ref_mem[base + k];
            end
            exp_rsp.push_back(line);
            n_rd++;
        end
        last_cmd = expected_cmd(r);
        last_wr  = (r.op == OP_WRITE);
        n_acc++;
    endtask

    task automatic send_request(input user_req_t r);
        int t;
        int start;
        t           = 0;
        start       = n_acc;
        i_req       = r;
        i_req_valid = 1'b1;
        while (n_acc == start && t < REQ_TIMEOUT) begin
            @(negedge clk);
            t++;
        end
        if (n_acc == start) begin
            $display("timeout: request %0d was never accepted", start);
            timed_out = 1'b1;
        end
        i_req_valid = 1'b0;
    endtask

    always @(posedge clk) begin
        if (rst_x_async) begin
            if (!i_init_calib_complete) begin
                check("o_req_ready", o_req_ready, 1'b0);
            end
            if (acc_d) begin
                check("o_app_cmd", app_cmd, last_cmd);
                if (last_wr) begin
                    check("o_app_wdf.wren", app_wdf.wren, 1'b1);
                end
            end
            if (cmd_held) begin
                check("o_app_cmd", app_cmd, held_cmd);
            end
            if (wdf_held) begin
                check("o_app_wdf", app_wdf, held_wdf);
            end
            if (rsp_due) begin
                check("o_rsp_valid", o_rsp_valid, 1'b1);
            end
            if (app_cmd.en && app_rdy) begin
                n_cmd++;
                if (app_cmd.cmd == CMD_READ) begin
                    n_rd_cmd++;
                end
                if (exp_cmd.size() == 0) begin
                    report_failure("command issued with no accepted request waiting");
                end else begin
                    check("o_app_cmd", app_cmd, exp_cmd.pop_front());
                end
            end
            if (app_wdf.wren && app_wdf_rdy) begin
                n_wdf++;
                if (exp_wdf.size() == 0) begin
                    report_failure("write beat issued with no accepted write waiting");
                end else begin
                    check("o_app_wdf", app_wdf, exp_wdf.pop_front());
                end
            end
            if (o_rsp_valid && i_rsp_ready) begin
                n_rsp++;
                if (exp_rsp.size() == 0) begin
                    report_failure("response delivered with no read waiting");
                end else begin
                    check("o_rsp_data", o_rsp_data, exp_rsp.pop_front());
                end
            end
            check("reads_in_flight_ok", (n_rd_cmd - n_rsp) <= RD_DEPTH, 1'b1);
            cmd_held = app_cmd.en && !app_rdy;
            held_cmd = app_cmd;
            wdf_held = app_wdf.wren && !app_wdf_rdy;
            held_wdf = app_wdf;
            rsp_due  = rd_valid && !o_rsp_valid;
            acc_d    = i_req_valid && o_req_ready;
            if (acc_d) begin
                record_accept(i_req);
            end
        end
    end

    // user side stalls on the response channel
    initial begin
        i_rsp_ready = 1'b0;
        forever begin
            @(negedge clk);
            i_rsp_ready = ($urandom % 8) < 5;
        end
    end

    initial begin
        user_req_t r;
        int        i;
        int        t;
        int        b;
        void'($urandom(10373));
        rst_x_async           = 1'b0;
        i_init_calib_complete = 1'b0;
        i_req_valid           = 1'b0;
        i_req                 = '0;
        n_checks  = 0;
        n_err     = 0;
        n_acc     = 0;
        n_wr      = 0;
        n_rd      = 0;
        n_cmd     = 0;
        n_rd_cmd  = 0;
        n_wdf     = 0;
        n_rsp     = 0;
        timed_out = 1'b0;
        acc_d     = 1'b0;
        last_wr   = 1'b0;
        cmd_held  = 1'b0;
        wdf_held  = 1'b0;
        rsp_due   = 1'b0;
        for (b = 0; b < 64 * 16; b++) begin
            ref_mem[b] = 8'((b * 37) ^ (b >> 8));
        end
        repeat (10) @(negedge clk);
        check("o_req_ready", o_req_ready, 1'b0);
        check("o_app_cmd.en", app_cmd.en, 1'b0);
        check("o_app_wdf.wren", app_wdf.wren, 1'b0);
        check("o_rsp_valid", o_rsp_valid, 1'b0);
        rst_x_async = 1'b1;
        // offered before calibration, must wait
        r           = random_request();
        i_req       = r;
        i_req_valid = 1'b1;
        repeat (8) @(negedge clk);
        check("n_acc", n_acc, 0);
        i_init_calib_complete = 1'b1;
        send_request(r);
        i = 1;
        while (i < N_REQ && !timed_out) begin
            if ($urandom % 4 == 0) begin
                @(negedge clk);
            end
            send_request(random_request());
            i++;
        end
        t = 0;
        while (!timed_out && (n_rsp != n_rd || n_cmd != n_acc || n_wdf != n_wr) &&
               t < DRAIN_TIMEOUT) begin
            @(negedge clk);
            t++;
        end
        if (!timed_out && (n_rsp != n_rd || n_cmd != n_acc || n_wdf != n_wr)) begin
            $display("timeout: commands, write beats or responses still outstanding");
            timed_out = 1'b1;
        end
        $display("checks %0d errors %0d req %0d wr %0d rd %0d cmd %0d beat %0d rsp %0d",
                 n_checks, n_err, n_acc, n_wr, n_rd, n_cmd, n_wdf, n_rsp);
        if (n_err == 0 && !timed_out) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

/* dram_app_bridge.f */
dram_app_pkg.sv
app_cmd_port.sv
app_wdf_port.sv
req_dispatch.sv
rd_return_fifo.sv
dram_app_bridge.sv
tb_app_mem_model.sv
tb_dram_app_bridge.sv

/* run_sim.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_dram_app_bridge \
    -f dram_app_bridge.f \
    --Mdir obj_dir -o sim_tb
./obj_dir/sim_tb | tee sim.log
if grep -q "^TB PASSED$" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi
